/* rob_top.f */
rob_pkg.sv
rob_ptr_ctr.sv
rob_entry_store.sv
rob_commit_fsm.sv
rob_top.sv
tb_rob_top.sv

/* Bender.yml */
package:
  name: rob_top

sources:
  - rob_pkg.sv
  - rob_ptr_ctr.sv
  - rob_entry_store.sv
  - rob_commit_fsm.sv
  - rob_top.sv
  - target: test
    files:
      - tb_rob_top.sv

/* tb_rob_top.sv */
`timescale 1ns/100ps

module tb_rob_top import rob_pkg::*;;

    localparam int TB_DEPTH    = 8;
    localparam int N_ROWS      = 28;
    localparam int N_TESTS     = 6;
    localparam int WATCHDOG_NS = (N_ROWS * 50 + 100) * 4;

    typedef struct packed {
        reg_name_t rd;
        logic      is_store;
        logic      pred;
        logic      taken;
        data_t     data;
        addr_t     target;
    } row_t;

    // rd, store, predicted, actual, data, target
    localparam row_t ROWS [N_ROWS] = '{
        '{5'd1,  1'b0, 1'b0, 1'b0, 32'h1000_0001, 32'h0000_1004},
        '{5'd2,  1'b0, 1'b0, 1'b0, 32'h1000_0002, 32'h0000_1008},
        '{5'd3,  1'b0, 1'b0, 1'b0, 32'h1000_0003, 32'h0000_100c},
        '{5'd4,  1'b0, 1'b0, 1'b0, 32'h1000_0004, 32'h0000_1010},
        '{5'd5,  1'b0, 1'b0, 1'b0, 32'h2000_0005, 32'h0000_1014},
        '{5'd6,  1'b0, 1'b0, 1'b0, 32'h2000_0006, 32'h0000_1018},
        '{5'd0,  1'b0, 1'b1, 1'b1, 32'h2000_0007, 32'h0000_1800},
        '{5'd7,  1'b0, 1'b0, 1'b0, 32'h2000_0008, 32'h0000_1804},
        '{5'd8,  1'b0, 1'b0, 1'b0, 32'h2000_0009, 32'h0000_1808},
        '{5'd0,  1'b1, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000},
        '{5'd9,  1'b0, 1'b0, 1'b0, 32'h3000_000a, 32'h0000_1810},
        '{5'd0,  1'b1, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000},
        '{5'd10, 1'b0, 1'b0, 1'b0, 32'h3000_000c, 32'h0000_1818},
        '{5'd11, 1'b0, 1'b0, 1'b0, 32'h4000_000d, 32'h0000_181c},
        '{5'd12, 1'b0, 1'b0, 1'b0, 32'h4000_000e, 32'h0000_1820},
        '{5'd13, 1'b0, 1'b0, 1'b0, 32'h4000_000f, 32'h0000_1824},
        '{5'd14, 1'b0, 1'b0, 1'b0, 32'h4000_0010, 32'h0000_1828},
        '{5'd15, 1'b0, 1'b0, 1'b0, 32'h4000_0011, 32'h0000_182c},
        '{5'd16, 1'b0, 1'b0, 1'b0, 32'h4000_0012, 32'h0000_1830},
        '{5'd17, 1'b0, 1'b0, 1'b0, 32'h4000_0013, 32'h0000_1834},
        '{5'd18, 1'b0, 1'b0, 1'b0, 32'h4000_0014, 32'h0000_1838},
        '{5'd19, 1'b0, 1'b0, 1'b0, 32'h5000_0015, 32'h0000_2000},
        '{5'd0,  1'b0, 1'b1, 1'b0, 32'h5000_0016, 32'h0000_2008},
        '{5'd20, 1'b0, 1'b0, 1'b0, 32'h5000_0017, 32'h0000_200c},
        '{5'd0,  1'b1, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000},
        '{5'd21, 1'b0, 1'b0, 1'b0, 32'h6000_0019, 32'h0000_2014},
        '{5'd0,  1'b1, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000},
        '{5'd22, 1'b0, 1'b0, 1'b1, 32'h6000_001b, 32'h0000_3000}
    };

    string test_name  [N_TESTS] = '{"basic", "wrap", "store", "full", "mispredict", "restart"};
    int    test_start [N_TESTS] = '{0, 4, 9, 13, 21, 25};
    int    test_count [N_TESTS] = '{4, 5, 4, 8, 4, 3};
    logic  test_fill  [N_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

    logic                        clk;
    logic                        arst_n;
    logic                        alloc_en;
    reg_name_t                   alloc_rd;
    logic                        alloc_is_store;
    logic                        alloc_pred_taken;
    logic                        alloc_ready;
    logic [$clog2(TB_DEPTH)-1:0] alloc_tag;
    logic                        wb_en;
    logic [$clog2(TB_DEPTH)-1:0] wb_tag;
    data_t                       wb_data;
    logic                        wb_taken;
    addr_t                       wb_target;
    logic                        rf_we;
    reg_name_t                   rf_rd;
    data_t                       rf_data;
    logic [$clog2(TB_DEPTH)-1:0] rf_tag;
    logic                        store_commit_en;
    logic [$clog2(TB_DEPTH)-1:0] store_commit_tag;
    logic                        store_done;
    logic                        flush;
    addr_t                       redirect_pc;

    integer seed = 32'h9dc0bf51;
    string  cur_test = "reset";
    int     error_count = 0;
    int     exp_rows[$];
    int     exp_pos = 0;
    int     exp_tail = 0;
    int     row_tag [N_ROWS];
    logic   store_open = 1'b0;
    logic   store_acked = 1'b0;
    logic   window_flushes;

    rob_top #(
        .ROB_DEPTH (TB_DEPTH)
    ) uut (
        .clk              (clk),
        .arst_n           (arst_n),
        .alloc_en         (alloc_en),
        .alloc_rd         (alloc_rd),
        .alloc_is_store   (alloc_is_store),
        .alloc_pred_taken (alloc_pred_taken),
        .alloc_ready      (alloc_ready),
        .alloc_tag        (alloc_tag),
        .wb_en            (wb_en),
        .wb_tag           (wb_tag),
        .wb_data          (wb_data),
        .wb_taken         (wb_taken),
        .wb_target        (wb_target),
        .rf_we            (rf_we),
        .rf_rd            (rf_rd),
        .rf_data          (rf_data),
        .rf_tag           (rf_tag),
        .store_commit_en  (store_commit_en),
        .store_commit_tag (store_commit_tag),
        .store_done       (store_done),
        .flush            (flush),
        .redirect_pc      (redirect_pc)
    );

    always #2 clk = ~clk;

    task automatic report_mismatch(input string what, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        error_count++;
        $display("Error: test %s, %s expected 0x%0h, actual 0x%0h", cur_test, what,
                 exp_val, act_val);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic report_problem(input string what);
        error_count++;
        $display("Error: test %s, %s", cur_test, what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // back to back allocation, tags recorded while the entry is offered
    task automatic allocate_window(input int start, input int count);
        int   k;
        logic stop;
        stop = 1'b0;
        window_flushes = 1'b0;
        for (k = start; k < start + count; k++) begin
            @(posedge clk);
            alloc_en         <= 1'b1;
            alloc_rd         <= ROWS[k].rd;
            alloc_is_store   <= ROWS[k].is_store;
            alloc_pred_taken <= ROWS[k].pred;
            @(negedge clk);
            while (!alloc_ready) begin
                @(negedge clk);
            end
            assert (alloc_tag == exp_tail) else report_mismatch("alloc_tag", exp_tail, alloc_tag);
            row_tag[k] = alloc_tag;
            exp_tail = (exp_tail + 1) % TB_DEPTH;
            if (!stop) begin
                exp_rows.push_back(k);
            end
            // younger rows behind a mispredict are never retired
            if (!ROWS[k].is_store && (ROWS[k].pred != ROWS[k].taken)) begin
                stop = 1'b1;
                window_flushes = 1'b1;
            end
        end
        @(posedge clk);
        alloc_en <= 1'b0;
    endtask

    task automatic write_back_window(input int start, input int count);
        int order[$];
        int j;
        int k;
        int tmp;
        for (k = start; k < start + count; k++) begin
            if (!ROWS[k].is_store) begin
                order.push_back(k);
            end
        end
        for (k = order.size() - 1; k > 0; k--) begin
            j = $unsigned($random(seed)) % (k + 1);
            tmp = order[k];
            order[k] = order[j];
            order[j] = tmp;
        end
        for (k = 0; k < order.size(); k++) begin
            @(posedge clk);
            wb_en     <= 1'b1;
            wb_tag    <= row_tag[order[k]];
            wb_data   <= ROWS[order[k]].data;
            wb_taken  <= ROWS[order[k]].taken;
            wb_target <= ROWS[order[k]].target;
        end
        @(posedge clk);
        wb_en <= 1'b0;
    endtask

    // store buffer model
    initial begin : store_responder
        int unsigned wait_cycles;
        forever begin
            @(negedge clk);
            if (store_commit_en === 1'b1) begin
                wait_cycles = $unsigned($random(seed)) % 4;
                repeat (wait_cycles) @(posedge clk);
                @(posedge clk);
                store_done <= 1'b1;
                @(posedge clk);
                store_done <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin : commit_monitor
        row_t r;
        if (arst_n) begin
            if (store_commit_en && !store_open) begin
                if (exp_pos >= exp_rows.size()) begin
                    report_problem("store released with nothing left to retire");
                end else begin
                    r = ROWS[exp_rows[exp_pos]];
                    assert (r.is_store) else report_problem("store released out of order");
                    assert (store_commit_tag == row_tag[exp_rows[exp_pos]])
                        else report_mismatch("store_commit_tag", row_tag[exp_rows[exp_pos]],
                                             store_commit_tag);
                    store_open  = 1'b1;
                    store_acked = store_done;
                end
            end else if (store_commit_en) begin
                assert (store_commit_tag == row_tag[exp_rows[exp_pos]])
                    else report_mismatch("store_commit_tag", row_tag[exp_rows[exp_pos]],
                                         store_commit_tag);
                if (store_done) begin
                    store_acked = 1'b1;
                end
            end else if (store_open) begin
                assert (store_acked) else report_problem("store_commit_en fell before store_done");
                store_open = 1'b0;
                exp_pos++;
            end
            if (rf_we) begin
                if (exp_pos >= exp_rows.size()) begin
                    report_problem("register commit with nothing left to retire");
                end else begin
                    r = ROWS[exp_rows[exp_pos]];
                    assert (!r.is_store) else report_problem("register commit while a store waits");
                    assert (rf_rd == r.rd) else report_mismatch("rf_rd", r.rd, rf_rd);
                    assert (rf_data == r.data) else report_mismatch("rf_data", r.data, rf_data);
                    assert (rf_tag == row_tag[exp_rows[exp_pos]])
                        else report_mismatch("rf_tag", row_tag[exp_rows[exp_pos]], rf_tag);
                    assert (flush == (r.pred != r.taken))
                        else report_mismatch("flush", (r.pred != r.taken), flush);
                    if (flush) begin
                        assert (redirect_pc == r.target)
                            else report_mismatch("redirect_pc", r.target, redirect_pc);
                        assert (!alloc_ready) else report_problem("alloc_ready high during a flush");
                    end else begin
                        assert (alloc_ready) else report_problem("alloc_ready low after a commit");
                    end
                    exp_pos++;
                end
            end else begin
                assert (!flush) else report_problem("flush raised without a register commit");
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        report_problem("the run did not finish in time");
    end

    initial begin : main_sequence
        int t;
        clk              = 1'b0;
        arst_n           = 1'b0;
        alloc_en         = 1'b0;
        alloc_rd         = '0;
        alloc_is_store   = 1'b0;
        alloc_pred_taken = 1'b0;
        wb_en            = 1'b0;
        wb_tag           = '0;
        wb_data          = '0;
        wb_taken         = 1'b0;
        wb_target        = '0;
        store_done       = 1'b0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        assert (!rf_we && !store_commit_en && !flush && !alloc_ready)
            else report_problem("outputs active during reset");
        @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        assert (!rf_we && !store_commit_en && !flush)
            else report_problem("commit outputs active after reset");
        assert (alloc_ready) else report_mismatch("alloc_ready", 1, alloc_ready);

        for (t = 0; t < N_TESTS; t++) begin
            cur_test = test_name[t];
            allocate_window(test_start[t], test_count[t]);
            if (test_fill[t]) begin
                @(negedge clk);
                assert (!alloc_ready) else report_problem("alloc_ready high with the buffer full");
            end
            write_back_window(test_start[t], test_count[t]);
            while (exp_pos < exp_rows.size()) begin
                @(negedge clk);
            end
            // stray commits of discarded rows would show up here
            repeat (4) @(negedge clk);
            if (window_flushes) begin
                exp_tail = 0;
            end
        end

        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* rob_top.sv */
`timescale 1ns/100ps

module rob_top import rob_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         arst_n,
    // allocation
    input  logic                         alloc_en,
    input  reg_name_t                    alloc_rd,
    input  logic                         alloc_is_store,
    input  logic                         alloc_pred_taken,
    output logic                         alloc_ready,
    output logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
    // writeback
    input  logic                         wb_en,
    input  logic [$clog2(ROB_DEPTH)-1:0] wb_tag,
    input  data_t                        wb_data,
    input  logic                         wb_taken,
    input  addr_t                        wb_target,
    // register commit
    output logic                         rf_we,
    output reg_name_t                    rf_rd,
    output data_t                        rf_data,
    output logic [$clog2(ROB_DEPTH)-1:0] rf_tag,
    // store commit
    output logic                         store_commit_en,
    output logic [$clog2(ROB_DEPTH)-1:0] store_commit_tag,
    input  logic                         store_done,
    // redirect
    output logic                         flush,
    output addr_t                        redirect_pc
);

    localparam int TAG_W = $clog2(ROB_DEPTH);

    logic [TAG_W-1:0] head;
    logic [TAG_W-1:0] tail;
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;
    logic             clear;
    logic             flushing;

    logic      head_valid;
    logic      head_live;
    logic      head_done;
    logic      head_is_store;
    logic      head_mispred;
    reg_name_t head_rd;
    data_t     head_data;
    addr_t     head_target;

    assign alloc_ready = !full && !flushing;
    assign alloc_tag   = tail;
    assign push        = alloc_en && alloc_ready;

    // never retire from an empty buffer
    assign head_live = head_valid && !empty;

    rob_ptr_ctr #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_ptr_ctr (
        .clk    (clk),
        .arst_n (arst_n),
        .push   (push),
        .pop    (pop),
        .clear  (clear),
        .head   (head),
        .tail   (tail),
        .full   (full),
        .empty  (empty)
    );

    rob_entry_store #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_entry_store (
        .clk              (clk),
        .arst_n           (arst_n),
        .clear            (clear),
        .pop              (pop),
        .alloc_we         (push),
        .alloc_tag        (tail),
        .alloc_rd         (alloc_rd),
        .alloc_is_store   (alloc_is_store),
        .alloc_pred_taken (alloc_pred_taken),
        .wb_en            (wb_en),
        .wb_tag           (wb_tag),
        .wb_data          (wb_data),
        .wb_taken         (wb_taken),
        .wb_target        (wb_target),
        .head             (head),
        .head_valid       (head_valid),
        .head_done        (head_done),
        .head_is_store    (head_is_store),
        .head_mispred     (head_mispred),
        .head_rd          (head_rd),
        .head_data        (head_data),
        .head_target      (head_target)
    );

    rob_commit_fsm #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_commit_fsm (
        .clk              (clk),
        .arst_n           (arst_n),
        .head_valid       (head_live),
        .head_done        (head_done),
        .head_is_store    (head_is_store),
        .head_mispred     (head_mispred),
        .head_rd          (head_rd),
        .head_data        (head_data),
        .head_target      (head_target),
        .head             (head),
        .store_done       (store_done),
        .rf_we            (rf_we),
        .rf_rd            (rf_rd),
        .rf_data          (rf_data),
        .rf_tag           (rf_tag),
        .store_commit_en  (store_commit_en),
        .store_commit_tag (store_commit_tag),
        .flush            (flush),
        .redirect_pc      (redirect_pc),
        .pop              (pop),
        .clear            (clear),
        .flushing         (flushing)
    );

endmodule

/* rob_commit_fsm.sv */
`timescale 1ns/100ps

module rob_commit_fsm import rob_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         head_valid,
    input  logic                         head_done,
    input  logic                         head_is_store,
    input  logic                         head_mispred,
    input  reg_name_t                    head_rd,
    input  data_t                        head_data,
    input  addr_t                        head_target,
    input  logic [$clog2(ROB_DEPTH)-1:0] head,
    input  logic                         store_done,
    // register commit
    output logic                         rf_we,
    output reg_name_t                    rf_rd,
    output data_t                        rf_data,
    output logic [$clog2(ROB_DEPTH)-1:0] rf_tag,
    // store commit
    output logic                         store_commit_en,
    output logic [$clog2(ROB_DEPTH)-1:0] store_commit_tag,
    // redirect
    output logic                         flush,
    output addr_t                        redirect_pc,
    // to pointers and storage
    output logic                         pop,
    output logic                         clear,
    output logic                         flushing
);

    commit_state_t state;
    commit_state_t state_next;

    logic reg_retire;
    logic store_start;

    // a done non-store head can leave the buffer this cycle
    assign reg_retire  = (state == COMMIT_RUN) && head_valid && !head_is_store && head_done;
    assign store_start = (state == COMMIT_RUN) && head_valid && head_is_store;

    always_comb begin
        state_next = state;
        pop        = 1'b0;
        clear      = 1'b0;
        case (state)
            COMMIT_RUN: begin
                if (store_start) begin
                    state_next = COMMIT_STORE_WAIT;
                end else if (reg_retire) begin
                    // a mispredicted head is dropped by the clear instead
                    if (head_mispred) begin
                        state_next = COMMIT_FLUSH;
                    end else begin
                        pop = 1'b1;
                    end
                end
            end
            COMMIT_STORE_WAIT: begin
                if (store_done) begin
                    pop        = 1'b1;
                    state_next = COMMIT_RUN;
                end
            end
            COMMIT_FLUSH: begin
                clear      = 1'b1;
                state_next = COMMIT_RUN;
            end
            default: begin
                state_next = COMMIT_RUN;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state           <= COMMIT_RUN;
            rf_we           <= 1'b0;
            store_commit_en <= 1'b0;
            flush           <= 1'b0;
            // holds allocation off until the first edge after reset
            flushing        <= 1'b1;
        end else begin
            state           <= state_next;
            rf_we           <= reg_retire;
            store_commit_en <= (state_next == COMMIT_STORE_WAIT);
            flush           <= reg_retire && head_mispred;
            flushing        <= (state_next == COMMIT_FLUSH);
        end
    end

    always_ff @(posedge clk) begin
        if (reg_retire) begin
            rf_rd   <= head_rd;
            rf_data <= head_data;
            rf_tag  <= head;
        end
        // tag stays put for the whole store wait
        if (store_start) begin
            store_commit_tag <= head;
        end
        if (reg_retire && head_mispred) begin
            redirect_pc <= head_target;
        end
    end

endmodule

/* rob_entry_store.sv */
`timescale 1ns/100ps

module rob_entry_store import rob_pkg::*; #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         clear,
    input  logic                         pop,
    // allocation
    input  logic                         alloc_we,
    input  logic [$clog2(ROB_DEPTH)-1:0] alloc_tag,
    input  reg_name_t                    alloc_rd,
    input  logic                         alloc_is_store,
    input  logic                         alloc_pred_taken,
    // writeback
    input  logic                         wb_en,
    input  logic [$clog2(ROB_DEPTH)-1:0] wb_tag,
    input  data_t                        wb_data,
    input  logic                         wb_taken,
    input  addr_t                        wb_target,
    // head entry
    input  logic [$clog2(ROB_DEPTH)-1:0] head,
    output logic                         head_valid,
    output logic                         head_done,
    output logic                         head_is_store,
    output logic                         head_mispred,
    output reg_name_t                    head_rd,
    output data_t                        head_data,
    output addr_t                        head_target
);

    logic [ROB_DEPTH-1:0] valid_q;
    logic [ROB_DEPTH-1:0] done_q;

    logic [ROB_DEPTH-1:0] store_q;
    logic [ROB_DEPTH-1:0] pred_q;
    logic [ROB_DEPTH-1:0] taken_q;
    reg_name_t            rd_q     [ROB_DEPTH];
    data_t                data_q   [ROB_DEPTH];
    addr_t                target_q [ROB_DEPTH];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            done_q  <= '0;
        end else if (clear) begin
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            if (pop) begin
                valid_q[head] <= 1'b0;
                done_q[head]  <= 1'b0;
            end
            if (alloc_we) begin
                valid_q[alloc_tag] <= 1'b1;
                done_q[alloc_tag]  <= 1'b0;
            end
            if (wb_en) begin
                done_q[wb_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_we) begin
            rd_q[alloc_tag]    <= alloc_rd;
            store_q[alloc_tag] <= alloc_is_store;
            pred_q[alloc_tag]  <= alloc_pred_taken;
        end
        // target is the fall-through pc for a branch that was not taken
        if (wb_en) begin
            data_q[wb_tag]   <= wb_data;
            taken_q[wb_tag]  <= wb_taken;
            target_q[wb_tag] <= wb_target;
        end
    end

    assign head_valid    = valid_q[head];
    assign head_done     = done_q[head];
    assign head_is_store = store_q[head];
    assign head_rd       = rd_q[head];
    assign head_data     = data_q[head];
    assign head_target   = target_q[head];

    // only a written-back entry has a real direction
    assign head_mispred = valid_q[head] && done_q[head] && (pred_q[head] != taken_q[head]);

endmodule

/* rob_ptr_ctr.sv */
`timescale 1ns/100ps

module rob_ptr_ctr #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         push,
    input  logic                         pop,
    input  logic                         clear,
    output logic [$clog2(ROB_DEPTH)-1:0] head,
    output logic [$clog2(ROB_DEPTH)-1:0] tail,
    output logic                         full,
    output logic                         empty
);

    localparam int TAG_W = $clog2(ROB_DEPTH);
    localparam logic [TAG_W:0] FULL_CNT = (TAG_W+1)'(ROB_DEPTH);

    // one extra bit so a full buffer differs from an empty one
    logic [TAG_W:0] count;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (clear) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // pointers wrap on their own since depth is a power of two
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign full  = (count == FULL_CNT);
    assign empty = (count == '0);

endmodule

/* rob_pkg.sv */
package rob_pkg;

    // widths of the architectural values
    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int REG_NAME_W = 5;

    // result value from an execution unit
    typedef logic [DATA_W-1:0]     data_t;

    // instruction address, branch target and redirect pc
    typedef logic [ADDR_W-1:0]     addr_t;

    // architectural register name
    typedef logic [REG_NAME_W-1:0] reg_name_t;

    // commit controller states
    typedef enum logic [1:0] {
        COMMIT_RUN,
        COMMIT_STORE_WAIT,
        COMMIT_FLUSH
    } commit_state_t;

endpackage
